// File: sources.f
+incdir+rtl
rtl/dary_pkg.sv
rtl/spram_bank.sv
rtl/spram_256x196.sv
rtl/dary_access_ctrl.sv
rtl/dary_top.sv
test/dary_assertions.sv
test/dary_tb.sv

// File: test/dary_tb.sv
// Data array testbench
`timescale 1ns/1ps
`default_nettype none

`include "dary_params.svh"

module dary_tb;

  // About 56 handshakes of 5 cycles plus reset and held cycles
  localparam int TIMEOUT_CYCLES = 400;
  // Limit for a single ack edge
  localparam int ACK_WAIT_MAX   = 20;
  localparam int SWEEP_OPS      = 40;

  logic                CLK;
  logic                rst_n;
  logic                req;
  dary_pkg::dary_req_t req_pkt;
  logic                ack;
  dary_pkg::dary_rsp_t rsp;

  integer seed   = 66795;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     assert_errors;

  // Expected line contents and the segments holding known data
  dary_pkg::line_t     model [`DARY_ENTRIES];
  dary_pkg::seg_mask_t known [`DARY_ENTRIES];

  dary_top dut0 (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .req     (req),
    .req_pkt (req_pkt),
    .rsp     (rsp),
    .ack     (ack)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  // Run limit
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Masked segments take wdata and the rest keep the old line
  function automatic dary_pkg::line_t merge_line(input dary_pkg::line_t old_line,
                                                 input dary_pkg::line_t wdata,
                                                 input dary_pkg::seg_mask_t mask);
    dary_pkg::line_t res;
    res = old_line;
    if (mask[0]) res.tag = wdata.tag;
    for (int n = 1; n < `DARY_NSEG; n++) begin
      if (mask[n]) res.data[n] = wdata.data[n];
    end
    return res;
  endfunction

  // All-ones over the selected segments
  function automatic dary_pkg::line_t seg_bits(input dary_pkg::seg_mask_t mask);
    dary_pkg::line_t bits;
    bits = '0;
    if (mask[0]) bits.tag = '1;
    for (int n = 1; n < `DARY_NSEG; n++) begin
      if (mask[n]) bits.data[n] = '1;
    end
    return bits;
  endfunction

  task automatic random_line(output dary_pkg::line_t line);
    logic [7*32-1:0] raw;
    raw = '0;
    // Seven words cover the 196 bits
    for (int k = 0; k < 7; k++) begin
      raw = {raw[6*32-1:0], 32'($random(seed))};
    end
    line = raw[`DARY_LINE_W-1:0];
  endtask

  // Compare only the bits marked in care
  task automatic check_rdata(input string what, input dary_pkg::line_t got,
                             input dary_pkg::line_t expv, input dary_pkg::line_t care);
    checks++;
    assert ((got & care) === (expv & care)) else begin
      errors++;
      $display("[FAIL] rsp.rdata = %h, expected %h (%s)", got & care, expv & care, what);
    end
  endtask

  // One full four-phase handshake with req optionally held after ack
  task automatic run_access(input logic wr, input logic [`DARY_IDX_W-1:0] idx,
                            input dary_pkg::seg_mask_t mask, input dary_pkg::line_t wdata,
                            input int hold, output dary_pkg::line_t rdata,
                            output int rise_lat, output int fall_wait);
    int waited;
    req_pkt.write = wr;
    req_pkt.index = idx;
    req_pkt.mask  = mask;
    req_pkt.wdata = wdata;
    req           = 1'b1;
    waited        = 0;
    do begin
      @(posedge CLK);
      #1;
      waited++;
    end while (!ack && waited < ACK_WAIT_MAX);
    checks++;
    assert (ack === 1'b1) else begin
      errors++;
      $display("ack did not rise within %0d cycles for index %0h", waited, idx);
    end
    // First waited edge is the one that sampled req
    rise_lat = waited - 1;
    rdata    = rsp.rdata;
    // ack and rsp must hold under back-pressure
    repeat (hold) begin
      @(posedge CLK);
      #1;
      checks++;
      assert (ack === 1'b1) else begin
        errors++;
        $display("[FAIL] ack = %h while req held, expected 1", ack);
      end
      assert (rsp.rdata === rdata) else begin
        errors++;
        $display("[FAIL] rsp.rdata = %h while req held, expected %h", rsp.rdata, rdata);
      end
    end
    req    = 1'b0;
    waited = 0;
    do begin
      @(posedge CLK);
      #1;
      waited++;
    end while (ack && waited < ACK_WAIT_MAX);
    checks++;
    assert (ack === 1'b0) else begin
      errors++;
      $display("ack did not fall within %0d cycles after req dropped", waited);
    end
    fall_wait = waited;
  endtask

  // Write with model update and echo check
  task automatic write_line(input logic [`DARY_IDX_W-1:0] idx, input dary_pkg::seg_mask_t mask,
                            input dary_pkg::line_t wdata, output dary_pkg::line_t rdata);
    int lat;
    int fw;
    run_access(1'b1, idx, mask, wdata, 0, rdata, lat, fw);
    model[idx] = merge_line(model[idx], wdata, mask);
    known[idx] = known[idx] | mask;
    check_rdata("write echo", rdata, model[idx], seg_bits(known[idx]));
  endtask

  task automatic read_line(input logic [`DARY_IDX_W-1:0] idx, output dary_pkg::line_t rdata);
    int lat;
    int fw;
    run_access(1'b0, idx, '0, '0, 0, rdata, lat, fw);
    check_rdata("read", rdata, model[idx], seg_bits(known[idx]));
  endtask

  task automatic test_reset_write_read();
    dary_pkg::line_t wdata;
    dary_pkg::line_t rdata;
    checks++;
    assert (ack === 1'b0) else begin
      errors++;
      $display("[FAIL] ack = %h after reset, expected 0", ack);
    end
    random_line(wdata);
    write_line(8'h10, '1, wdata, rdata);
    read_line(8'h10, rdata);
    check_rdata("full line read", rdata, wdata, '1);
  endtask

  task automatic test_masked_write();
    dary_pkg::line_t base;
    dary_pkg::line_t wdata;
    dary_pkg::line_t expv;
    dary_pkg::line_t rdata;
    random_line(base);
    write_line(8'h21, '1, base, rdata);
    random_line(wdata);
    write_line(8'h21, 5'b01010, wdata, rdata);
    // New segments 1 and 3 over old tag and segments 2 and 4
    expv         = base;
    expv.data[1] = wdata.data[1];
    expv.data[3] = wdata.data[3];
    check_rdata("masked echo", rdata, expv, '1);
    read_line(8'h21, rdata);
    check_rdata("masked read", rdata, expv, '1);
  endtask

  task automatic test_segment_bounds();
    dary_pkg::line_t          wdata;
    dary_pkg::line_t          rdata;
    dary_pkg::seg_mask_t      mask;
    logic [`DARY_LINE_W-1:0]  exp_raw;
    logic [`DARY_SEG_W-1:0]   pat;
    logic [`DARY_IDX_W-1:0]   idx;
    for (int n = 0; n < `DARY_NSEG; n++) begin
      idx = `DARY_IDX_W'(8'h40 + n);
      write_line(idx, '1, '0, rdata);
      // All-ones in unmasked segments must not leak in
      wdata   = '1;
      pat     = 48'h5a3c_96e1_0f00 + n;
      exp_raw = '0;
      mask    = '0;
      mask[n] = 1'b1;
      if (n == 0) begin
        wdata.tag = 4'ha;
        exp_raw[`DARY_LINE_W-1 -: `DARY_TAG_W] = 4'ha;
      end else begin
        wdata.data[n] = pat;
        // Segment 4 sits at bits 47:0 and each lower index 48 bits higher
        exp_raw = {{(`DARY_LINE_W-`DARY_SEG_W){1'b0}}, pat} << (`DARY_SEG_W * (4 - n));
      end
      write_line(idx, mask, wdata, rdata);
      check_rdata("segment bit range", rdata, exp_raw, '1);
    end
  endtask

  task automatic test_handshake_timing();
    dary_pkg::line_t wdata;
    dary_pkg::line_t rdata;
    int              lat;
    int              fw;
    random_line(wdata);
    run_access(1'b1, 8'h77, '1, wdata, 4, rdata, lat, fw);
    model[8'h77] = wdata;
    known[8'h77] = '1;
    check_rdata("held echo", rdata, wdata, '1);
    checks++;
    assert (lat == 3) else begin
      errors++;
      $display("ack rose %0d cycles after req was sampled, expected 3", lat);
    end
    checks++;
    assert (fw == 1) else begin
      errors++;
      $display("ack took %0d cycles to fall after req dropped, expected 1", fw);
    end
  endtask

  task automatic test_random_sweep();
    dary_pkg::line_t        wdata;
    dary_pkg::line_t        rdata;
    dary_pkg::seg_mask_t    mask;
    logic [`DARY_IDX_W-1:0] idx;
    logic [`DARY_IDX_W-1:0] used [$];
    logic                   is_write;
    for (int i = 0; i < SWEEP_OPS; i++) begin
      is_write = (i < 2) ? 1'b1 : 1'($random(seed));
      if (is_write) begin
        // Both ends of the index range first
        if (i == 0) idx = '0;
        else if (i == 1) idx = '1;
        else if (used.size() > 0 && $random(seed) % 2 == 0)
          idx = used[$unsigned($random(seed)) % used.size()];
        else idx = `DARY_IDX_W'($random(seed));
        mask = (i < 2) ? '1 : dary_pkg::seg_mask_t'($random(seed));
        random_line(wdata);
        write_line(idx, mask, wdata, rdata);
        used.push_back(idx);
      end else begin
        idx = used[$unsigned($random(seed)) % used.size()];
        read_line(idx, rdata);
      end
    end
  endtask

  initial begin
    CLK     = 1'b0;
    rst_n   = 1'b0;
    req     = 1'b0;
    req_pkt = '0;
    for (int k = 0; k < `DARY_ENTRIES; k++) begin
      known[k] = '0;
    end
    repeat (2) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    test_reset_write_read();
    test_masked_write();
    test_segment_bounds();
    test_handshake_timing();
    test_random_sweep();
    assert_errors = dut0.u_ctrl.u_assert.fail_cnt;
    $display("Checks run: %0d, check errors: %0d, assertion errors: %0d",
             checks, errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/dary_assertions.sv
// Handshake and macro pin assertions
`timescale 1ns/1ps
`default_nettype none

module dary_assertions (
  input wire                      CLK,
  input wire                      rst_n,
  input wire                      req,
  input wire dary_pkg::dary_req_t req_pkt,
  input wire                      ack,
  input wire                      CEN,
  input wire                      GWEN
);

  // Running count of failed assertions
  int fail_cnt = 0;

  // Request fields frozen while req stays high
  req_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    req && $past(req) |-> $stable(req_pkt))
  else begin
    $error("req_pkt changed while req was high");
    fail_cnt++;
  end

  // ack only answers a raised req
  ack_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
  else begin
    $error("ack rose without a pending req");
    fail_cnt++;
  end

  // One enabled cycle followed by idle pins until ack
  cen_single: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(CEN) |=> CEN [*2] ##1 (CEN && ack))
  else begin
    $error("CEN was not low for exactly one cycle before ack");
    fail_cnt++;
  end

  // Write enable only in the enabled cycle of a write request
  gwen_in_cen: assert property (@(posedge CLK) disable iff (!rst_n)
    !GWEN |-> !CEN && req_pkt.write)
  else begin
    $error("GWEN low outside the enabled cycle of a write request");
    fail_cnt++;
  end

endmodule

// Attach to every controller instance
bind dary_access_ctrl dary_assertions u_assert (
  .CLK     (CLK),
  .rst_n   (rst_n),
  .req     (req),
  .req_pkt (req_pkt),
  .ack     (ack),
  .CEN     (CEN),
  .GWEN    (GWEN)
);

`default_nettype wire

// File: rtl/dary_top.sv
// Data array top level
`timescale 1ns/1ps
`default_nettype none

module dary_top (
  input  wire                      CLK,
  input  wire                      rst_n,
  input  wire                      req,
  input  wire dary_pkg::dary_req_t req_pkt,
  output dary_pkg::dary_rsp_t      rsp,
  output logic                     ack
);

  // Macro pin nets
  logic [7:0]              mem_a;
  logic                    mem_cen;
  logic                    mem_gwen;
  logic [195:0]            mem_wen;
  dary_pkg::line_t         mem_d;
  dary_pkg::line_t         mem_q;

  // Handshake and pin sequencing
  dary_access_ctrl u_ctrl (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .req     (req),
    .req_pkt (req_pkt),
    .ack     (ack),
    .rsp     (rsp),
    .A       (mem_a),
    .CEN     (mem_cen),
    .GWEN    (mem_gwen),
    .WEN     (mem_wen),
    .D       (mem_d),
    .Q       (mem_q)
  );

  // Line storage
  spram_256x196 u_array (
    .CLK  (CLK),
    .A    (mem_a),
    .CEN  (mem_cen),
    .GWEN (mem_gwen),
    .WEN  (mem_wen),
    .D    (mem_d),
    .Q    (mem_q)
  );

endmodule

`default_nettype wire

// File: rtl/dary_access_ctrl.sv
// Data array access controller
`timescale 1ns/1ps
`default_nettype none

`include "dary_params.svh"

module dary_access_ctrl (
  input  wire                      CLK,
  input  wire                      rst_n,
  // Four-phase request port
  input  wire                      req,
  input  wire dary_pkg::dary_req_t req_pkt,
  output logic                     ack,
  output dary_pkg::dary_rsp_t      rsp,
  // Macro pins
  output logic [`DARY_IDX_W-1:0]   A,
  output logic                     CEN,
  output logic                     GWEN,
  output logic [`DARY_LINE_W-1:0]  WEN,
  output dary_pkg::line_t          D,
  input  wire dary_pkg::line_t     Q
);

  // idle -> access -> capture -> respond -> idle
  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_capture,
    st_respond
  } state_t;

  state_t state;

  // Request taken at edge 0
  dary_pkg::dary_req_t req_q;

  // Active-low per-bit write enables
  dary_pkg::line_t     wen_line;

  // Access cycle flags
  logic                in_access;
  logic                do_write;

  // Handshake and access sequencing
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      ack   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // New access only once req and ack were both low
          if (req && !ack) begin
            state <= st_access;
          end
        end
        // Macro enabled this cycle
        st_access: begin
          state <= st_capture;
        end
        // Q valid this cycle, taken into rsp
        st_capture: begin
          state <= st_respond;
        end
        st_respond: begin
          if (!ack) begin
            // Edge 3 after req was seen
            ack <= 1'b1;
          end else if (!req) begin
            // Return to zero, requester has let go
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Request register, loaded when the access starts
  always_ff @(posedge CLK) begin
    if (state == st_idle && req) begin
      req_q <= req_pkt;
    end
  end

  // Response capture at edge 2, held through back-pressure
  always_ff @(posedge CLK) begin
    if (state == st_capture) begin
      rsp.rdata <= Q;
    end
  end

  assign in_access = (state == st_access);
  assign do_write  = in_access && req_q.write;

  // Mask expansion, a set mask bit pulls its whole segment low
  always_comb begin
    wen_line = '1;
    if (do_write) begin
      wen_line.tag = {`DARY_TAG_W{~req_q.mask[0]}};
      for (int n = 1; n < `DARY_NSEG; n++) begin
        wen_line.data[n] = {`DARY_SEG_W{~req_q.mask[n]}};
      end
    end
  end

  // Pins follow the request register
  assign A    = req_q.index;
  assign D    = req_q.wdata;
  assign CEN  = ~in_access;
  // Global write only for write requests
  assign GWEN = ~do_write;
  assign WEN  = wen_line;

endmodule

`default_nettype wire

// File: rtl/spram_256x196.sv
// 256x196 single-port array wrapper
`timescale 1ns/1ps
`default_nettype none

`include "dary_params.svh"

module spram_256x196 (
  input  wire                    CLK,
  input  wire [`DARY_IDX_W-1:0]  A,
  input  wire                    CEN,
  input  wire                    GWEN,
  input  wire [`DARY_LINE_W-1:0] WEN,
  input  wire dary_pkg::line_t   D,
  output dary_pkg::line_t        Q
);

  // Address held from the last enabled cycle
  logic [`DARY_IDX_W-1:0] addr_hold;
  // Address seen by all five banks
  logic [`DARY_IDX_W-1:0] addr;

  // Tag bank signals
  logic                   tag_wen;
  dary_pkg::tag_seg_t     tag_dout;

  // Data bank signals, one entry per segment
  logic                   data_wen  [1:`DARY_NSEG-1];
  dary_pkg::data_seg_t    data_dout [1:`DARY_NSEG-1];

  // Capture the address while enabled
  always_ff @(posedge CLK) begin
    if (!CEN) begin
      addr_hold <= A;
    end
  end

  // Disabled cycles reuse the held address so Q stays put
  assign addr = CEN ? addr_hold : A;

  // Tag segment enable from the top WEN bit of the line
  assign tag_wen = !CEN && !GWEN && !WEN[`DARY_LINE_W-1];

  spram_bank #(
    .word_t (dary_pkg::tag_seg_t),
    .DEPTH  (`DARY_ENTRIES)
  ) u_bank_tag (
    .CLK  (CLK),
    .addr (addr),
    .din  (D.tag),
    .wen  (tag_wen),
    .dout (tag_dout)
  );

  // Data segments 1 to 4, one bank each
  for (genvar gi = 1; gi < `DARY_NSEG; gi++) begin : g_data_bank

    // Top bit of this segment, i.e. 191, 143, 95, 47
    localparam int WEN_BIT = `DARY_LINE_W - 1 - `DARY_TAG_W - (gi - 1) * `DARY_SEG_W;

    assign data_wen[gi] = !CEN && !GWEN && !WEN[WEN_BIT];

    spram_bank #(
      .word_t (dary_pkg::data_seg_t),
      .DEPTH  (`DARY_ENTRIES)
    ) u_bank_data (
      .CLK  (CLK),
      .addr (addr),
      .din  (D.data[gi]),
      .wen  (data_wen[gi]),
      .dout (data_dout[gi])
    );

  end

  // Join the banks back into a line, tag first
  assign Q = {tag_dout, data_dout[1], data_dout[2], data_dout[3], data_dout[4]};

endmodule

`default_nettype wire

// File: rtl/spram_bank.sv
// Single-port RAM bank
`timescale 1ns/1ps
`default_nettype none

`include "dary_params.svh"

module spram_bank #(
  parameter type word_t = logic [`DARY_SEG_W-1:0],
  parameter int  DEPTH  = `DARY_ENTRIES
) (
  input  wire                    CLK,
  input  wire [`DARY_IDX_W-1:0]  addr,
  input  wire word_t             din,
  input  wire                    wen,
  output word_t                  dout
);

  // Storage, contents undefined after power-up
  word_t mem [DEPTH];

  // Read address, sampled on every edge
  logic [`DARY_IDX_W-1:0] addr_q;

  // Write at the edge where wen is high
  always_ff @(posedge CLK) begin
    if (wen) begin
      mem[addr] <= din;
    end
  end

  always_ff @(posedge CLK) begin
    addr_q <= addr;
  end

  // Registered address selects the word,
  // so a write shows up here one cycle later
  assign dout = mem[addr_q];

endmodule

`default_nettype wire

// File: rtl/dary_pkg.sv
// Data array shared types
`default_nettype none

`include "dary_params.svh"

package dary_pkg;

  // Tag and flag segment
  typedef logic [`DARY_TAG_W-1:0] tag_seg_t;

  // One data segment
  typedef logic [`DARY_SEG_W-1:0] data_seg_t;

  // Full line, tag in the top bits
  // data[1] follows the tag, data[4] sits at bits 47:0
  typedef struct packed {
    tag_seg_t                          tag;
    data_seg_t [1:`DARY_NSEG-1]        data;
  } line_t;

  // Bit n set writes segment n, bit 0 is the tag
  typedef logic [`DARY_NSEG-1:0] seg_mask_t;

  // Request as held by the requester during a handshake
  typedef struct packed {
    logic                   write;
    logic [`DARY_IDX_W-1:0] index;
    seg_mask_t              mask;
    line_t                  wdata;
  } dary_req_t;

  // Line at the index after the access
  typedef struct packed {
    line_t rdata;
  } dary_rsp_t;

endpackage

`default_nettype wire

// File: rtl/dary_params.svh
// Data array sizing macros
`ifndef DARY_PARAMS_SVH
`define DARY_PARAMS_SVH

// Index into the line array
`define DARY_IDX_W 8

// Lines held by every bank
`define DARY_ENTRIES 256

// Segment 0, tag and flag bits
`define DARY_TAG_W 4

// Segments 1 to 4, data payload
`define DARY_SEG_W 48

// Tag segment plus four data segments
`define DARY_NSEG 5

// Full line, tag on top
`define DARY_LINE_W 196

`endif
